/* compile.f */
verilog/ci_pkg.sv
verilog/reset_boot.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/cmd_fsm.sv
verilog/bus_arbiter.sv
verilog/ci_memory.sv
verilog/ci_top.sv
verif/ci_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator; exit status is the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ci_tb \
    -f compile.f -o ci_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/ci_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit 1
fi

exit 0

/* verif/ci_tb.sv */
`timescale 1ns/1ps

module ci_tb import ci_pkg::*; ();

    // About 200 commands of up to 100 bit periods each
    localparam int TIMEOUT_CYCLES = 200 * 100 * CLKS_PER_BIT;
    localparam int NUM_HOST_OPS   = 40;
    localparam int NUM_CORE_OPS   = 20;
    localparam int NUM_BAD_OPS    = 10;

    logic    clk;
    logic    reset_i;
    logic    rx_i;
    logic    tx_o;
    wb_req_t core_req_i;
    wb_rsp_t core_rsp_o;
    logic    core_reset_o;

    integer      seed = 94;
    int          cycles;
    logic        boot_done;
    logic [7:0]  reply_q[$];
    logic [31:0] written_q[$];
    logic [31:0] core_q[$];
    logic [31:0] model_mem [MEM_WORDS];

    ci_top i_ci_top (
        .clk          (clk),
        .reset_i      (reset_i),
        .rx_i         (rx_i),
        .tx_o         (tx_o),
        .core_req_i   (core_req_i),
        .core_rsp_o   (core_rsp_o),
        .core_reset_o (core_reset_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run exceeded %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("test failed");
        $fatal(1, "timeout");
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "check %s", name);
        end
    endtask

    // Host side of the UART sending 8N1 frames LSB first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_i <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic send_word(input logic [31:0] w);
        for (int i = 3; i >= 0; i--) begin
            send_byte(w[i*8 +: 8]);
        end
    endtask

    // Collects every frame on tx_o by sampling near mid-bit on the falling clock edge
    initial begin : tx_monitor
        logic [7:0] b;
        while (boot_done !== 1'b1) @(negedge clk);
        forever begin
            @(negedge clk);
            if (tx_o === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    b[i] = tx_o;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                if (tx_o !== 1'b1) begin
                    $display("Stop bit of a reply byte on tx_o was not high");
                    $display("test failed");
                    $fatal(1, "framing");
                end else begin
                    reply_q.push_back(b);
                end
            end
        end
    end

    task automatic recv_byte(output logic [7:0] b);
        while (reply_q.size() == 0) @(posedge clk);
        b = reply_q.pop_front();
    endtask

    task automatic host_command(input logic [7:0] code, output logic [7:0] rsp);
        send_byte(code);
        recv_byte(rsp);
    endtask

    task automatic host_write(input logic [31:0] adr, input logic [31:0] dat);
        logic [7:0] rsp;
        send_byte(OP_WRITE);
        send_word(adr);
        send_word(dat);
        recv_byte(rsp);
        check("host write reply", 32'(RSP_ACK), 32'(rsp));
    endtask

    task automatic host_read(input logic [31:0] adr, output logic [31:0] dat);
        logic [7:0] b;
        send_byte(OP_READ);
        send_word(adr);
        for (int i = 3; i >= 0; i--) begin
            recv_byte(b);
            dat[i*8 +: 8] = b;
        end
    endtask

    // Core side of the Wishbone port
    task automatic wait_core_ack();
        do @(negedge clk); while (core_rsp_o.ack !== 1'b1);
    endtask

    task automatic core_write(input logic [31:0] adr, input logic [31:0] dat);
        @(posedge clk);
        core_req_i <= {1'b1, 1'b1, 1'b1, adr, dat};
        wait_core_ack();
        @(posedge clk);
        core_req_i <= '0;
    endtask

    task automatic core_read(input logic [31:0] adr, output logic [31:0] dat);
        @(posedge clk);
        core_req_i <= {1'b1, 1'b1, 1'b0, adr, 32'h0};
        wait_core_ack();
        dat = core_rsp_o.dat;
        @(posedge clk);
        core_req_i <= '0;
    endtask

    // Request held for 50 cycles, then dropped without an ack
    task automatic core_probe_halted(input logic [31:0] adr);
        @(posedge clk);
        core_req_i <= {1'b1, 1'b1, 1'b0, adr, 32'h0};
        repeat (50) begin
            @(negedge clk);
            check("halted core ack", 32'h0, 32'(core_rsp_o.ack));
        end
        @(posedge clk);
        core_req_i <= '0;
    endtask

    function automatic logic [31:0] rand_addr();
        logic [MEM_AW-1:0] idx;
        idx = MEM_AW'($random(seed));
        return 32'({idx, 2'b00});
    endfunction

    function automatic logic [31:0] pick_written();
        return written_q[$unsigned($random(seed)) % written_q.size()];
    endfunction

    initial begin : main
        logic [7:0]  rsp;
        logic [7:0]  code;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [31:0] got;
        reset_i    = 1'b1;
        rx_i       = 1'b1;
        core_req_i = '0;
        boot_done  = 1'b0;
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;
        // Controller stays in reset for BOOT_CYCLES after reset_i
        repeat (BOOT_CYCLES + 2) @(posedge clk);
        @(negedge clk);
        check("tx idle after reset", 32'h1, 32'(tx_o));
        check("core reset after reset", 32'h1, 32'(core_reset_o));
        check("core ack after reset", 32'h0, 32'(core_rsp_o.ack));
        boot_done = 1'b1;

        host_command(OP_PING, rsp);
        check("ping reply", 32'(HARNESS_ID), 32'(rsp));
        check("core reset after ping", 32'h1, 32'(core_reset_o));

        for (int i = 0; i < NUM_HOST_OPS; i++) begin
            adr = rand_addr();
            dat = $random(seed);
            host_write(adr, dat);
            model_mem[adr[MEM_AW+1:2]] = dat;
            written_q.push_back(adr);
        end
        for (int i = 0; i < NUM_HOST_OPS; i++) begin
            adr = pick_written();
            host_read(adr, got);
            check("host read", model_mem[adr[MEM_AW+1:2]], got);
        end

        core_probe_halted(written_q[0]);

        host_command(OP_RUN, rsp);
        check("run reply", 32'(RSP_ACK), 32'(rsp));
        check("core reset after run", 32'h0, 32'(core_reset_o));
        for (int i = 0; i < NUM_CORE_OPS; i++) begin
            adr = rand_addr();
            dat = $random(seed);
            core_write(adr, dat);
            model_mem[adr[MEM_AW+1:2]] = dat;
            written_q.push_back(adr);
            core_q.push_back(adr);
        end
        for (int i = 0; i < NUM_CORE_OPS; i++) begin
            adr = pick_written();
            core_read(adr, got);
            check("core read", model_mem[adr[MEM_AW+1:2]], got);
        end

        host_command(OP_HALT, rsp);
        check("halt reply", 32'(RSP_ACK), 32'(rsp));
        check("core reset after halt", 32'h1, 32'(core_reset_o));
        foreach (core_q[i]) begin
            host_read(core_q[i], got);
            check("read of core data", model_mem[core_q[i][MEM_AW+1:2]], got);
        end

        for (int i = 0; i < NUM_BAD_OPS; i++) begin
            code = 8'($random(seed));
            // Keep clear of the valid opcodes
            if (code >= 8'h01 && code <= 8'h05) begin
                code = code ^ 8'h80;
            end
            host_command(code, rsp);
            check("unknown opcode reply", 32'(RSP_NAK), 32'(rsp));
        end
        for (int i = 0; i < NUM_HOST_OPS; i++) begin
            adr = pick_written();
            host_read(adr, got);
            check("read after unknown opcodes", model_mem[adr[MEM_AW+1:2]], got);
        end

        // Long enough for one more whole frame to reach the monitor
        repeat (12 * CLKS_PER_BIT) @(posedge clk);
        check("extra reply bytes", 32'h0, 32'(reply_q.size()));
        $display("test passed");
        $finish;
    end

endmodule

/* verilog/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter import ci_pkg::*; (
    input  logic    core_reset_i,
    input  wb_req_t ctl_req_i,
    output wb_rsp_t ctl_rsp_o,
    input  wb_req_t core_req_i,
    output wb_rsp_t core_rsp_o,
    output wb_req_t mem_req_o,
    input  wb_rsp_t mem_rsp_i
);

    // Owner follows the core reset line
    always_comb begin
        if (core_reset_i) begin
            mem_req_o = ctl_req_i;
        end else begin
            mem_req_o = core_req_i;
        end
    end

    // Read data goes to both, ack only to the owner
    always_comb begin
        ctl_rsp_o      = mem_rsp_i;
        ctl_rsp_o.ack  = mem_rsp_i.ack && core_reset_i;
        core_rsp_o     = mem_rsp_i;
        core_rsp_o.ack = mem_rsp_i.ack && !core_reset_i;
    end

    // During a halt the memory only answers controller cycles
    always_comb begin
        a_halt_ack_from_ctl: assert final (
            !(mem_rsp_i.ack && core_reset_i) || ctl_req_i.cyc
        );
    end

endmodule

/* verilog/ci_memory.sv */
`timescale 1ns/1ps

module ci_memory import ci_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o
);

    logic [31:0]       mem [MEM_WORDS];
    logic [MEM_AW-1:0] word_idx;
    logic [31:0]       rdata;
    logic              ack;
    logic              access;

    assign word_idx = req_i.adr[MEM_AW+1:2];

    // New access only when the previous ack is not still out
    assign access = req_i.cyc && req_i.stb && !ack;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (req_i.we) begin
                mem[word_idx] <= req_i.dat;
            end
            rdata <= mem[word_idx];
        end
    end

    assign rsp_o.ack = ack;
    assign rsp_o.dat = rdata;

    a_ack_after_stb: assert property (
        @(posedge clk) disable iff (reset_i)
        rsp_o.ack |-> $past(req_i.cyc && req_i.stb)
    );

    // Masters keep the cycle open until they see ack
    a_req_held: assert property (
        @(posedge clk) disable iff (reset_i)
        rsp_o.ack |-> (req_i.cyc && req_i.stb)
    );

endmodule

/* verilog/ci_pkg.sv */
package ci_pkg;

    // UART timing
    localparam int CLKS_PER_BIT = 8;
    localparam int TMR_W        = $clog2(CLKS_PER_BIT);

    // Controller reset stretch after reset_i
    localparam int BOOT_CYCLES = 16;
    localparam int BOOT_W      = $clog2(BOOT_CYCLES + 1);

    // Word memory, indexed by adr[MEM_AW+1:2]
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = $clog2(MEM_WORDS);

    // Host reply bytes
    localparam logic [7:0] HARNESS_ID = 8'h5A;
    localparam logic [7:0] RSP_ACK    = 8'h06;
    localparam logic [7:0] RSP_NAK    = 8'h15;

    // Wishbone classic request, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    // Wishbone classic response, slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef enum logic [7:0] {
        OP_PING  = 8'h01,
        OP_WRITE = 8'h02,
        OP_READ  = 8'h03,
        OP_RUN   = 8'h04,
        OP_HALT  = 8'h05
    } opcode_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_BUS,
        S_REPLY,
        S_WAIT_TX
    } fsm_state_e;

endpackage

/* verilog/ci_top.sv */
`timescale 1ns/1ps

module ci_top import ci_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    input  logic    rx_i,
    output logic    tx_o,
    input  wb_req_t core_req_i,
    output wb_rsp_t core_rsp_o,
    output logic    core_reset_o
);

    logic       ctl_reset;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;
    wb_req_t    ctl_req;
    wb_rsp_t    ctl_rsp;
    wb_req_t    mem_req;
    wb_rsp_t    mem_rsp;

    reset_boot i_reset_boot (
        .clk         (clk),
        .reset_i     (reset_i),
        .ctl_reset_o (ctl_reset)
    );

    uart_rx i_uart_rx (
        .clk        (clk),
        .reset_i    (ctl_reset),
        .rx_i       (rx_i),
        .rx_data_o  (rx_data),
        .rx_valid_o (rx_valid)
    );

    uart_tx i_uart_tx (
        .clk        (clk),
        .reset_i    (ctl_reset),
        .tx_start_i (tx_start),
        .tx_data_i  (tx_data),
        .tx_o       (tx_o),
        .tx_busy_o  (tx_busy)
    );

    cmd_fsm i_cmd_fsm (
        .clk          (clk),
        .reset_i      (ctl_reset),
        .rx_data_i    (rx_data),
        .rx_valid_i   (rx_valid),
        .tx_busy_i    (tx_busy),
        .tx_data_o    (tx_data),
        .tx_start_o   (tx_start),
        .bus_req_o    (ctl_req),
        .bus_rsp_i    (ctl_rsp),
        .core_reset_o (core_reset_o)
    );

    bus_arbiter i_bus_arbiter (
        .core_reset_i (core_reset_o),
        .ctl_req_i    (ctl_req),
        .ctl_rsp_o    (ctl_rsp),
        .core_req_i   (core_req_i),
        .core_rsp_o   (core_rsp_o),
        .mem_req_o    (mem_req),
        .mem_rsp_i    (mem_rsp)
    );

    ci_memory i_ci_memory (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (mem_req),
        .rsp_o   (mem_rsp)
    );

endmodule

/* verilog/cmd_fsm.sv */
`timescale 1ns/1ps

module cmd_fsm import ci_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic [7:0] rx_data_i,
    input  logic       rx_valid_i,
    input  logic       tx_busy_i,
    output logic [7:0] tx_data_o,
    output logic       tx_start_o,
    output wb_req_t    bus_req_o,
    input  wb_rsp_t    bus_rsp_i,
    output logic       core_reset_o
);

    fsm_state_e  state;
    opcode_e     op;
    logic [1:0]  byte_cnt;
    logic [1:0]  reply_left;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] reply;

    // First reply byte for commands answered straight from S_IDLE
    function automatic logic [7:0] op_reply(input logic [7:0] code);
        case (opcode_e'(code))
            OP_PING:         return HARNESS_ID;
            OP_RUN, OP_HALT: return RSP_ACK;
            default:         return RSP_NAK;
        endcase
    endfunction

    // One classic cycle, held for the whole of S_BUS
    always_comb begin
        bus_req_o.cyc = (state == S_BUS);
        bus_req_o.stb = (state == S_BUS);
        bus_req_o.we  = (op == OP_WRITE);
        bus_req_o.adr = addr;
        bus_req_o.dat = wdata;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state        <= S_IDLE;
            op           <= OP_PING;
            byte_cnt     <= '0;
            reply_left   <= '0;
            tx_start_o   <= 1'b0;
            core_reset_o <= 1'b1;
        end else begin
            tx_start_o <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (rx_valid_i) begin
                        op         <= opcode_e'(rx_data_i);
                        byte_cnt   <= '0;
                        reply_left <= '0;
                        case (opcode_e'(rx_data_i))
                            OP_WRITE, OP_READ: state <= S_ADDR;
                            OP_RUN: begin
                                core_reset_o <= 1'b0;
                                state        <= S_REPLY;
                            end
                            OP_HALT: begin
                                core_reset_o <= 1'b1;
                                state        <= S_REPLY;
                            end
                            default: state <= S_REPLY;
                        endcase
                    end
                end
                S_ADDR: begin
                    if (rx_valid_i) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) begin
                            if (op == OP_WRITE) begin
                                state <= S_DATA;
                            end else begin
                                // No bus access while the core owns memory
                                state <= core_reset_o ? S_BUS : S_REPLY;
                            end
                        end
                    end
                end
                S_DATA: begin
                    if (rx_valid_i) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) begin
                            state <= core_reset_o ? S_BUS : S_REPLY;
                        end
                    end
                end
                S_BUS: begin
                    if (bus_rsp_i.ack) begin
                        reply_left <= (op == OP_READ) ? 2'd3 : 2'd0;
                        state      <= S_REPLY;
                    end
                end
                S_REPLY: begin
                    tx_start_o <= 1'b1;
                    state      <= S_WAIT_TX;
                end
                S_WAIT_TX: begin
                    // tx_busy_i rises a cycle after the start strobe
                    if (!tx_busy_i && !tx_start_o) begin
                        if (reply_left == 2'd0) begin
                            state <= S_IDLE;
                        end else begin
                            reply_left <= reply_left - 1'b1;
                            state      <= S_REPLY;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Address, data and reply bytes, MSB first
    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (rx_valid_i) begin
                    reply <= {op_reply(rx_data_i), 24'h0};
                end
            end
            S_ADDR: begin
                if (rx_valid_i) begin
                    addr  <= {addr[23:0], rx_data_i};
                    // Stands if the bus cycle is skipped
                    reply <= {RSP_NAK, 24'h0};
                end
            end
            S_DATA: begin
                if (rx_valid_i) begin
                    wdata <= {wdata[23:0], rx_data_i};
                    reply <= {RSP_NAK, 24'h0};
                end
            end
            S_BUS: begin
                if (bus_rsp_i.ack) begin
                    reply <= (op == OP_READ) ? bus_rsp_i.dat : {RSP_ACK, 24'h0};
                end
            end
            S_REPLY: begin
                tx_data_o <= reply[31:24];
                reply     <= {reply[23:0], 8'h00};
            end
            default: ;
        endcase
    end

    // Controller only drives the bus while it holds the core in reset
    a_ctl_owns_bus: assert property (
        @(posedge clk) disable iff (reset_i)
        bus_req_o.stb |-> (bus_req_o.cyc && core_reset_o)
    );

endmodule

/* verilog/reset_boot.sv */
`timescale 1ns/1ps

module reset_boot import ci_pkg::*; (
    input  logic clk,
    input  logic reset_i,
    output logic ctl_reset_o
);

    logic [BOOT_W-1:0] count;

    // Count down after reset_i falls, release on the last step
    always_ff @(posedge clk) begin
        if (reset_i) begin
            count       <= BOOT_W'(BOOT_CYCLES);
            ctl_reset_o <= 1'b1;
        end else begin
            if (count != '0) begin
                count <= count - 1'b1;
            end
            ctl_reset_o <= (count > BOOT_W'(1));
        end
    end

endmodule

/* verilog/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx import ci_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       rx_i,
    output logic [7:0] rx_data_o,
    output logic       rx_valid_o
);

    logic [1:0]       rx_sync;
    logic             rx_bit;
    logic             busy;
    logic [TMR_W-1:0] timer;
    logic [3:0]       bit_idx;
    logic [7:0]       shift;
    logic             sample;

    assign rx_bit = rx_sync[1];
    assign sample = busy && (timer == '0);

    // Two-flop synchronizer, idles high
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], rx_i};
        end
    end

    // Bit index 0 is the start bit, 1 to 8 data, 9 stop
    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy       <= 1'b0;
            timer      <= '0;
            bit_idx    <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (!busy) begin
                if (!rx_bit) begin
                    // Half a bit puts later samples at mid-period
                    busy    <= 1'b1;
                    timer   <= TMR_W'(CLKS_PER_BIT / 2 - 1);
                    bit_idx <= '0;
                end
            end else if (timer != '0) begin
                timer <= timer - 1'b1;
            end else begin
                timer   <= TMR_W'(CLKS_PER_BIT - 1);
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd0 && rx_bit) begin
                    // Start bit gone by mid-period, treat as a glitch
                    busy <= 1'b0;
                end else if (bit_idx == 4'd9) begin
                    busy       <= 1'b0;
                    rx_valid_o <= rx_bit;
                end
            end
        end
    end

    // Data arrives LSB first
    always_ff @(posedge clk) begin
        if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            shift <= {rx_bit, shift[7:1]};
        end
    end

    assign rx_data_o = shift;

endmodule

/* verilog/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx import ci_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       tx_start_i,
    input  logic [7:0] tx_data_i,
    output logic       tx_o,
    output logic       tx_busy_o
);

    logic [8:0]       shift;
    logic [TMR_W-1:0] timer;
    logic [3:0]       bit_cnt;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            tx_o      <= 1'b1;
            tx_busy_o <= 1'b0;
            timer     <= '0;
            bit_cnt   <= '0;
        end else if (!tx_busy_o) begin
            if (tx_start_i) begin
                // Start bit goes out right away
                tx_o      <= 1'b0;
                tx_busy_o <= 1'b1;
                timer     <= TMR_W'(CLKS_PER_BIT - 1);
                bit_cnt   <= '0;
            end
        end else if (timer != '0) begin
            timer <= timer - 1'b1;
        end else begin
            timer <= TMR_W'(CLKS_PER_BIT - 1);
            if (bit_cnt == 4'd9) begin
                // Stop bit has run its full period
                tx_busy_o <= 1'b0;
            end else begin
                tx_o    <= shift[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Data then stop bit, shifted out LSB first
    always_ff @(posedge clk) begin
        if (!tx_busy_o && tx_start_i) begin
            shift <= {1'b1, tx_data_i};
        end else if (tx_busy_o && timer == '0) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

    // The controller must wait out the frame before the next byte
    a_no_start_when_busy: assert property (
        @(posedge clk) disable iff (reset_i) !(tx_start_i && tx_busy_o)
    );

endmodule
